//--- verilog/alu_pkg.sv
`default_nettype none

package alu_pkg;

  // integer register width of the core
  localparam int XLEN = 32;

  // one data value as read from the register file
  typedef logic [XLEN-1:0] word;

  // shift amount, upper bits of a count are dropped per RISC-V
  typedef logic [$clog2(XLEN)-1:0] shift;

  // adder operand with one guard bit above the word
  // the guard bit carries the compare result for slt and sltu
  typedef logic [XLEN:0] adder_in;

  // selects the first stage logic result
  // pass forwards rs1 so that shifts and lui can use the funnel
  typedef enum logic [1:0] {
    ALU_BITWISE_AND,
    ALU_BITWISE_OR,
    ALU_BITWISE_XOR,
    ALU_BITWISE_PASS
  } alu_bitwise_t;

  // selects which second stage unit writes the result
  typedef enum logic {
    ALU_OUT_ADDER,
    ALU_OUT_SHIFT
  } alu_out_t;

  // decoded ALU operation with its source values already read
  typedef struct packed {
    word          pc;
    word          rs1;
    word          rs2;
    word          immediate;
    // take immediate instead of rs2 as second operand
    logic         is_immediate;
    // subtract, compare or shift left
    logic         negate;
    // signed compare, unsigned when low
    logic         flip_signs;
    // arithmetic right shift
    logic         sign_extend;
    // auipc adds to pc instead of rs1
    logic         pc_relative;
    // result is the zero extended compare bit
    logic         compare;
    alu_bitwise_t bitwise_select;
    alu_out_t     out_select;
  } alu_data_t;

endpackage

`default_nettype wire

//--- verilog/alu_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

module alu_dispatch #(
  parameter int NUM_LANES = 2
) (
  input  logic                 clk_core,
  input  logic                 rst_core,
  input  logic                 flush_req,
  input  logic                 in_valid,
  output logic                 in_ready,
  output logic [NUM_LANES-1:0] lane_valid,
  input  logic [NUM_LANES-1:0] lane_ready
);

  // a single lane still gets a one bit pointer
  localparam int PTR_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;
  localparam logic [PTR_W-1:0] LAST_LANE = PTR_W'(NUM_LANES - 1);

  logic [PTR_W-1:0] ptr;
  logic             xfer;

  // the selected lane alone decides whether the operation is taken
  assign in_ready = lane_ready[ptr];
  assign xfer     = in_valid & in_ready;

  // valid goes to the selected lane only, data is broadcast by the top
  always_comb begin
    for (int k = 0; k < NUM_LANES; k++) begin
      lane_valid[k] = in_valid && (ptr == PTR_W'(k));
    end
  end

  // round robin pointer, the merger walks the lanes in the same order
  always_ff @(posedge clk_core or negedge rst_core) begin
    if (!rst_core) begin
      ptr <= '0;
    end else if (flush_req) begin
      // restart at lane 0 so both pointers agree after a flush
      ptr <= '0;
    end else if (xfer) begin
      ptr <= (ptr == LAST_LANE) ? '0 : ptr + 1'b1;
    end
  end

  // an operation sent during a flush would be dropped by the lanes
  a_no_input_in_flush: assert property (@(posedge clk_core) disable iff (!rst_core)
    flush_req |-> !in_valid);

endmodule

`default_nettype wire

//--- verilog/alu_setup_stage.sv
`timescale 1ns/1ps
`default_nettype none

module alu_setup_stage (
  input  logic               clk_core,
  input  logic               stall,
  input  logic               flush_req,
  input  logic               in_valid,
  input  alu_pkg::alu_data_t in_alu_data,
  output logic               out_valid,
  output alu_pkg::alu_data_t out_alu_data,
  output alu_pkg::word       out_shift_lo,
  output alu_pkg::word       out_shift_hi,
  output alu_pkg::shift      out_shift_count,
  output alu_pkg::adder_in   out_adder_a,
  output alu_pkg::adder_in   out_adder_b
);

  import alu_pkg::*;

  word     rs1;
  word     opnd_b;
  logic    b_non_zero;
  logic    count_non_zero;
  logic    shift_left;
  shift    count;
  word     logic_q;
  word     fill_hi;
  adder_in a_ext;
  adder_in b_ext;
  adder_in b_neg;
  adder_in adder_a;
  adder_in adder_b;

  assign rs1    = in_alu_data.rs1;
  assign opnd_b = in_alu_data.is_immediate ? in_alu_data.immediate : in_alu_data.rs2;

  // full word test for sltu, low bits only for the shift count
  assign b_non_zero     = |opnd_b;
  assign count_non_zero = |opnd_b[$bits(shift)-1:0];

  // left shift by n is a right shift of {rs1, 0} by 32 - n
  // a left shift by zero stays a right shift by zero of rs1
  assign shift_left = in_alu_data.negate & count_non_zero;

  // only the pass path feeds the shifter, logic results go through unshifted
  always_comb begin
    if (in_alu_data.bitwise_select != ALU_BITWISE_PASS) begin
      count = '0;
    end else if (shift_left) begin
      count = -opnd_b[$bits(shift)-1:0];
    end else begin
      count = opnd_b[$bits(shift)-1:0];
    end
  end

  always_comb begin
    case (in_alu_data.bitwise_select)
      ALU_BITWISE_AND: logic_q = rs1 & opnd_b;
      ALU_BITWISE_OR:  logic_q = rs1 | opnd_b;
      ALU_BITWISE_XOR: logic_q = rs1 ^ opnd_b;
      // left shifts move rs1 into the upper funnel half
      default:         logic_q = shift_left ? '0 : rs1;
    endcase
  end

  // upper funnel half is rs1 for sll, sign copies for sra, zero for srl
  assign fill_hi = shift_left ? rs1 : {XLEN{in_alu_data.sign_extend & rs1[XLEN-1]}};

  // sign extend to the guard bit, then negate b for sub and compares
  assign a_ext = {rs1[XLEN-1], rs1};
  assign b_ext = {opnd_b[XLEN-1], opnd_b};
  assign b_neg = in_alu_data.negate ? -b_ext : b_ext;

  always_comb begin
    adder_a = a_ext;
    adder_b = b_neg;
    if (in_alu_data.flip_signs) begin
      // signed values become excess 2^31 so the guard bit orders them
      adder_a[XLEN] = ~a_ext[XLEN];
      adder_b[XLEN] = ~b_neg[XLEN];
    end else begin
      // unsigned a is never negative, negated b is negative unless zero
      adder_a[XLEN] = 1'b0;
      adder_b[XLEN] = b_non_zero;
    end
    // auipc adds the immediate to pc, guard bit unused here
    if (in_alu_data.pc_relative) begin
      adder_a = {1'b0, in_alu_data.pc};
    end
  end

  always_ff @(posedge clk_core) begin
    if (!stall) begin
      out_valid       <= in_valid;
      out_alu_data    <= in_alu_data;
      out_shift_lo    <= logic_q;
      out_shift_hi    <= fill_hi;
      out_shift_count <= count;
      out_adder_a     <= adder_a;
      out_adder_b     <= adder_b;
    end
    // flush wins over a held operation
    if (flush_req) begin
      out_valid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- verilog/alu_shift_add_stage.sv
`timescale 1ns/1ps
`default_nettype none

module alu_shift_add_stage (
  input  logic               clk_core,
  input  logic               stall,
  input  logic               flush_req,
  input  logic               in_valid,
  input  alu_pkg::alu_data_t in_alu_data,
  input  alu_pkg::word       in_shift_lo,
  input  alu_pkg::word       in_shift_hi,
  input  alu_pkg::shift      in_shift_count,
  input  alu_pkg::adder_in   in_adder_a,
  input  alu_pkg::adder_in   in_adder_b,
  output logic               out_valid,
  output alu_pkg::word       out_result,
  output alu_pkg::word       out_pc
);

  import alu_pkg::*;

  logic [2*XLEN-1:0] funnel;
  word               shift_q;
  word               sum_q;
  logic              carry;
  word               adder_q;

  // funnel shift right, the low word is the result for all shift kinds
  assign funnel  = {in_shift_hi, in_shift_lo} >> in_shift_count;
  assign shift_q = funnel[XLEN-1:0];

  // the guard bit of the sum is the a < b flag after the setup stage
  assign {carry, sum_q} = in_adder_a + in_adder_b;

  // slt and sltu write the flag zero extended
  assign adder_q = in_alu_data.compare ? word'(carry) : sum_q;

  always_ff @(posedge clk_core) begin
    if (!stall) begin
      out_valid <= in_valid;
      out_pc    <= in_alu_data.pc;
      case (in_alu_data.out_select)
        ALU_OUT_SHIFT: out_result <= shift_q;
        default:       out_result <= adder_q;
      endcase
    end
    if (flush_req) begin
      out_valid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- verilog/alu_skid_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module alu_skid_buffer #(
  parameter int WIDTH = 64
) (
  input  logic             clk_core,
  input  logic             rst_core,
  input  logic             flush_req,
  input  logic [WIDTH-1:0] in,
  input  logic             in_valid,
  output logic             in_ready,
  output logic [WIDTH-1:0] out,
  output logic             out_valid,
  input  logic             out_ready,
  output logic             stall
);

  logic [WIDTH-1:0] skid_data;
  logic             skid_valid;
  logic             push;
  logic             pop;
  logic             load_out;

  // skid entry only fills behind a valid output entry, so this means full
  assign stall    = skid_valid;
  assign in_ready = ~stall;

  assign push = in_valid & in_ready;
  assign pop  = out_valid & out_ready;

  // output register refills when empty or when its entry leaves
  assign load_out = pop | ~out_valid;

  always_ff @(posedge clk_core or negedge rst_core) begin
    if (!rst_core) begin
      out_valid  <= 1'b0;
      skid_valid <= 1'b0;
    end else if (flush_req) begin
      out_valid  <= 1'b0;
      skid_valid <= 1'b0;
    end else if (load_out) begin
      // older skid entry goes first, else new data passes straight in
      out_valid  <= skid_valid | push;
      skid_valid <= 1'b0;
    end else if (push) begin
      // output blocked, park the new result
      skid_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk_core) begin
    if (load_out) begin
      out <= skid_valid ? skid_data : in;
    end else if (push) begin
      skid_data <= in;
    end
  end

  // a result offered while full waits unchanged for a free entry
  a_skid_hold: assert property (@(posedge clk_core) disable iff (!rst_core)
    (stall && in_valid && !flush_req) |=> (in_valid && $stable(in)));

endmodule

`default_nettype wire

//--- verilog/alu_lane.sv
`timescale 1ns/1ps
`default_nettype none

module alu_lane (
  input  logic               clk_core,
  input  logic               rst_core,
  input  logic               flush_req,
  output logic               flush_ack,
  input  logic               in_valid,
  output logic               in_ready,
  input  alu_pkg::alu_data_t in_alu_data,
  output logic               out_valid,
  input  logic               out_ready,
  output alu_pkg::word       out_result,
  output alu_pkg::word       out_pc
);

  import alu_pkg::*;

  // one stall freezes both stages when the skid buffer is full
  logic      stall;
  logic      setup_valid;
  alu_data_t setup_data;
  word       shift_lo;
  word       shift_hi;
  shift      shift_count;
  adder_in   adder_a;
  adder_in   adder_b;
  logic      sa_valid;
  word       sa_result;
  word       sa_pc;

  alu_setup_stage setup (
    .clk_core,
    .stall,
    .flush_req,
    .in_valid,
    .in_alu_data,
    .out_valid      (setup_valid),
    .out_alu_data   (setup_data),
    .out_shift_lo   (shift_lo),
    .out_shift_hi   (shift_hi),
    .out_shift_count(shift_count),
    .out_adder_a    (adder_a),
    .out_adder_b    (adder_b)
  );

  alu_shift_add_stage shift_add (
    .clk_core,
    .stall,
    .flush_req,
    .in_valid      (setup_valid),
    .in_alu_data   (setup_data),
    .in_shift_lo   (shift_lo),
    .in_shift_hi   (shift_hi),
    .in_shift_count(shift_count),
    .in_adder_a    (adder_a),
    .in_adder_b    (adder_b),
    .out_valid     (sa_valid),
    .out_result    (sa_result),
    .out_pc        (sa_pc)
  );

  // result and pc travel together toward commit
  alu_skid_buffer #(
    .WIDTH(2 * XLEN)
  ) to_commit (
    .clk_core,
    .rst_core,
    .flush_req,
    .in       ({sa_result, sa_pc}),
    .in_valid (sa_valid),
    .in_ready,
    .out      ({out_result, out_pc}),
    .out_valid,
    .out_ready,
    .stall
  );

  always_ff @(posedge clk_core or negedge rst_core) begin
    if (!rst_core) begin
      flush_ack <= 1'b0;
    end else begin
      flush_ack <= flush_req;
    end
  end

  // ack comes one cycle later with the lane already empty at its output
  a_flush_ack: assert property (@(posedge clk_core) disable iff (!rst_core)
    flush_req |=> (flush_ack && !out_valid));

endmodule

`default_nettype wire

//--- verilog/alu_commit_merge.sv
`timescale 1ns/1ps
`default_nettype none

module alu_commit_merge #(
  parameter int NUM_LANES = 2
) (
  input  logic                 clk_core,
  input  logic                 rst_core,
  input  logic                 flush_req,
  input  logic [NUM_LANES-1:0] lane_valid,
  input  alu_pkg::word         lane_result [NUM_LANES],
  input  alu_pkg::word         lane_pc [NUM_LANES],
  output logic [NUM_LANES-1:0] lane_ready,
  input  logic [NUM_LANES-1:0] lane_flush_ack,
  output logic                 out_valid,
  input  logic                 out_ready,
  output alu_pkg::word         out_result,
  output alu_pkg::word         out_pc,
  output logic                 flush_ack
);

  localparam int PTR_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;
  localparam logic [PTR_W-1:0] LAST_LANE = PTR_W'(NUM_LANES - 1);

  logic [PTR_W-1:0] ptr;
  logic             xfer;

  // wait on the lane holding the oldest result, others may run ahead
  // nothing leaves while a flush is under way
  assign out_valid  = lane_valid[ptr] & ~flush_req;
  assign out_result = lane_result[ptr];
  assign out_pc     = lane_pc[ptr];
  assign xfer       = out_valid & out_ready;

  always_comb begin
    for (int k = 0; k < NUM_LANES; k++) begin
      lane_ready[k] = out_ready && !flush_req && (ptr == PTR_W'(k));
    end
  end

  // flush is done once every lane has answered
  assign flush_ack = &lane_flush_ack;

  // follows the dispatcher order so results retire in program order
  always_ff @(posedge clk_core or negedge rst_core) begin
    if (!rst_core) begin
      ptr <= '0;
    end else if (flush_req) begin
      ptr <= '0;
    end else if (xfer) begin
      ptr <= (ptr == LAST_LANE) ? '0 : ptr + 1'b1;
    end
  end

  // no stale result is offered once the lanes have seen a flush
  a_no_stale: assert property (@(posedge clk_core) disable iff (!rst_core)
    flush_req |=> !out_valid);

endmodule

`default_nettype wire

//--- verilog/alu_cluster.sv
`timescale 1ns/1ps
`default_nettype none

module alu_cluster #(
  parameter int NUM_LANES = 2
) (
  input  logic               clk_core,
  input  logic               rst_core,
  input  logic               in_valid,
  output logic               in_ready,
  input  alu_pkg::alu_data_t in_data,
  output logic               out_valid,
  input  logic               out_ready,
  output alu_pkg::word       out_result,
  output alu_pkg::word       out_pc,
  input  logic               flush_req,
  output logic               flush_ack
);

  import alu_pkg::*;

  logic [NUM_LANES-1:0] lane_in_valid;
  logic [NUM_LANES-1:0] lane_in_ready;
  logic [NUM_LANES-1:0] lane_out_valid;
  logic [NUM_LANES-1:0] lane_out_ready;
  logic [NUM_LANES-1:0] lane_flush_ack;
  word                  lane_result [NUM_LANES];
  word                  lane_pc [NUM_LANES];

  alu_dispatch #(
    .NUM_LANES(NUM_LANES)
  ) dispatch (
    .clk_core,
    .rst_core,
    .flush_req,
    .in_valid,
    .in_ready,
    .lane_valid(lane_in_valid),
    .lane_ready(lane_in_ready)
  );

  // every lane sees the operation, only the steered one gets valid
  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    alu_lane lane (
      .clk_core,
      .rst_core,
      .flush_req,
      .flush_ack  (lane_flush_ack[i]),
      .in_valid   (lane_in_valid[i]),
      .in_ready   (lane_in_ready[i]),
      .in_alu_data(in_data),
      .out_valid  (lane_out_valid[i]),
      .out_ready  (lane_out_ready[i]),
      .out_result (lane_result[i]),
      .out_pc     (lane_pc[i])
    );
  end

  alu_commit_merge #(
    .NUM_LANES(NUM_LANES)
  ) merge (
    .clk_core,
    .rst_core,
    .flush_req,
    .lane_valid    (lane_out_valid),
    .lane_result   (lane_result),
    .lane_pc       (lane_pc),
    .lane_ready    (lane_out_ready),
    .lane_flush_ack(lane_flush_ack),
    .out_valid,
    .out_ready,
    .out_result,
    .out_pc,
    .flush_ack
  );

endmodule

`default_nettype wire

//--- bench/alu_tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module alu_tb_clock #(
  parameter int PERIOD_NS    = 8,
  parameter int RESET_CYCLES = 5
) (
  output logic clk_core,
  output logic rst_core
);

  // free running core clock
  initial begin
    clk_core = 1'b0;
    forever #(PERIOD_NS / 2) clk_core = ~clk_core;
  end

  // reset held over the first rising edges, released away from them
  initial begin
    rst_core = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_core);
    @(negedge clk_core);
    rst_core = 1'b1;
  end

endmodule

`default_nettype wire

//--- bench/alu_cluster_tb.sv
`timescale 1ns/1ps
`default_nettype none

module alu_cluster_tb;

  import alu_pkg::*;

  // operation kinds used to build decoded operations
  localparam int OP_ADD   = 0;
  localparam int OP_SUB   = 1;
  localparam int OP_AND   = 2;
  localparam int OP_OR    = 3;
  localparam int OP_XOR   = 4;
  localparam int OP_SLL   = 5;
  localparam int OP_SRL   = 6;
  localparam int OP_SRA   = 7;
  localparam int OP_SLT   = 8;
  localparam int OP_SLTU  = 9;
  localparam int OP_LUI   = 10;
  localparam int OP_AUIPC = 11;
  localparam int NUM_KINDS = 12;

  // upper bound of directed, latency and flush operations
  localparam int DIRECTED_OPS = 100;
  localparam int NUM_RANDOM   = 2000;
  localparam int CYCLE_LIMIT  = 4 * (DIRECTED_OPS + NUM_RANDOM) + 1000;
  // out_ready high this long means nothing can still be blocked
  localparam int FREE_RUN     = 32;

  logic        clk_core;
  logic        rst_core;
  logic        in_valid;
  logic        in_ready;
  alu_data_t   in_data;
  logic        out_valid;
  logic        out_ready;
  word         out_result;
  word         out_pc;
  logic        flush_req;
  logic        flush_ack;

  // expected {result, pc} in program order
  logic [63:0] expected_q[$];
  logic [63:0] expected_entry;
  logic [31:0] rng_state;
  word         pc_counter;
  // 0 always ready, 1 random stalls, 2 held low
  int          ready_mode;
  int          ready_run;
  int          cycle_count;
  int          checked_count;

  alu_tb_clock #(
    .PERIOD_NS   (8),
    .RESET_CYCLES(5)
  ) clock_gen (
    .clk_core,
    .rst_core
  );

  alu_cluster #(
    .NUM_LANES(2)
  ) uut (
    .clk_core,
    .rst_core,
    .in_valid,
    .in_ready,
    .in_data,
    .out_valid,
    .out_ready,
    .out_result,
    .out_pc,
    .flush_req,
    .flush_ack
  );

  task automatic end_in_failure();
    $display("tests failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic stop_run(input string what);
    $display("Error at %0t ns: %s", $time, what);
    end_in_failure();
  endtask

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("Fail at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
      end_in_failure();
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_random();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // RISC-V result of one decoded operation
  function automatic word ref_result(input alu_data_t op);
    word        b;
    logic [4:0] shamt;
    word        r;
    b     = op.is_immediate ? op.immediate : op.rs2;
    // only the low five bits of a count matter
    shamt = b[4:0];
    if (op.out_select == ALU_OUT_SHIFT) begin
      case (op.bitwise_select)
        ALU_BITWISE_AND: r = op.rs1 & b;
        ALU_BITWISE_OR:  r = op.rs1 | b;
        ALU_BITWISE_XOR: r = op.rs1 ^ b;
        default: begin
          if (op.negate) begin
            r = op.rs1 << shamt;
          end else if (op.sign_extend) begin
            r = word'($signed(op.rs1) >>> shamt);
          end else begin
            r = op.rs1 >> shamt;
          end
        end
      endcase
    end else if (op.compare) begin
      if (op.flip_signs) begin
        r = ($signed(op.rs1) < $signed(b)) ? 32'd1 : 32'd0;
      end else begin
        r = (op.rs1 < b) ? 32'd1 : 32'd0;
      end
    end else if (op.pc_relative) begin
      r = op.pc + b;
    end else if (op.negate) begin
      r = op.rs1 - b;
    end else begin
      r = op.rs1 + b;
    end
    return r;
  endfunction

  // decoder view of one instruction, pc is filled in when sent
  function automatic alu_data_t make_op(input int kind, input word a, input word b,
                                        input word imm, input logic use_imm);
    alu_data_t op;
    op                = '0;
    op.rs1            = a;
    op.rs2            = b;
    op.immediate      = imm;
    op.is_immediate   = use_imm;
    op.bitwise_select = ALU_BITWISE_PASS;
    op.out_select     = ALU_OUT_SHIFT;
    case (kind)
      OP_ADD: op.out_select = ALU_OUT_ADDER;
      OP_SUB: begin
        op.out_select   = ALU_OUT_ADDER;
        op.negate       = 1'b1;
        op.is_immediate = 1'b0;
      end
      OP_AND: op.bitwise_select = ALU_BITWISE_AND;
      OP_OR:  op.bitwise_select = ALU_BITWISE_OR;
      OP_XOR: op.bitwise_select = ALU_BITWISE_XOR;
      OP_SLL: op.negate = 1'b1;
      OP_SRA: op.sign_extend = 1'b1;
      OP_SLT: begin
        op.out_select = ALU_OUT_ADDER;
        op.negate     = 1'b1;
        op.flip_signs = 1'b1;
        op.compare    = 1'b1;
      end
      OP_SLTU: begin
        op.out_select = ALU_OUT_ADDER;
        op.negate     = 1'b1;
        op.compare    = 1'b1;
      end
      // lui rides the pass path with the upper immediate on rs1 and a zero count
      OP_LUI: begin
        op.rs1          = imm;
        op.immediate    = '0;
        op.is_immediate = 1'b1;
      end
      OP_AUIPC: begin
        op.out_select   = ALU_OUT_ADDER;
        op.pc_relative  = 1'b1;
        op.is_immediate = 1'b1;
      end
      default: op.out_select = ALU_OUT_SHIFT;
    endcase
    return op;
  endfunction

  task automatic drive_ready();
    case (ready_mode)
      0:       out_ready = 1'b1;
      1:       out_ready = (next_random() % 3) != 0;
      default: out_ready = 1'b0;
    endcase
  endtask

  task automatic idle_cycle();
    @(negedge clk_core);
    drive_ready();
    in_valid = 1'b0;
    @(posedge clk_core);
  endtask

  // returns at the rising edge where the operation was taken
  task automatic send_op(input alu_data_t op);
    op.pc      = pc_counter;
    pc_counter = pc_counter + 32'd4;
    @(negedge clk_core);
    drive_ready();
    in_valid = 1'b1;
    in_data  = op;
    @(posedge clk_core);
    while (!in_ready) begin
      @(negedge clk_core);
      drive_ready();
      @(posedge clk_core);
    end
  endtask

  task automatic wait_drained();
    for (int i = 0; i < 200 && expected_q.size() != 0; i++) begin
      idle_cycle();
    end
  endtask

  // one cycle flush pulse, then outputs run freely again
  task automatic flush_cluster();
    @(negedge clk_core);
    in_valid  = 1'b0;
    flush_req = 1'b1;
    drive_ready();
    @(posedge clk_core);
    check_value(flush_ack, 1'b0, "flush_ack in the flush cycle");
    @(negedge clk_core);
    flush_req  = 1'b0;
    ready_mode = 0;
    drive_ready();
    @(posedge clk_core);
    check_value(flush_ack, 1'b1, "flush_ack one cycle after flush_req");
    check_value(out_valid, 1'b0, "out_valid after flush");
  endtask

  task automatic arith_ops();
    send_op(make_op(OP_ADD, 32'd5, 32'd7, '0, 1'b0));
    send_op(make_op(OP_ADD, 32'hffff_ffff, 32'd1, '0, 1'b0));
    send_op(make_op(OP_ADD, 32'd100, '0, 32'hffff_ffff, 1'b1));
    send_op(make_op(OP_SUB, 32'd3, 32'd5, '0, 1'b0));
    send_op(make_op(OP_SUB, 32'h8000_0000, 32'd1, '0, 1'b0));
    send_op(make_op(OP_AND, 32'hf0f0_1234, 32'h0ff0_ffff, '0, 1'b0));
    send_op(make_op(OP_AND, 32'hdead_beef, '0, 32'h0000_07f0, 1'b1));
    send_op(make_op(OP_OR, 32'h1200_0034, 32'h0056_0000, '0, 1'b0));
    send_op(make_op(OP_OR, 32'h0, '0, 32'hffff_f800, 1'b1));
    send_op(make_op(OP_XOR, 32'haaaa_5555, 32'hffff_0000, '0, 1'b0));
    send_op(make_op(OP_XOR, 32'h1357_9bdf, '0, 32'hffff_ffff, 1'b1));
    send_op(make_op(OP_LUI, '0, '0, 32'h1234_5000, 1'b1));
    send_op(make_op(OP_AUIPC, '0, '0, 32'hffff_f000, 1'b1));
  endtask

  task automatic shift_ops();
    // register counts above 31 keep only their low five bits
    send_op(make_op(OP_SLL, 32'h8000_0001, 32'd4, '0, 1'b0));
    send_op(make_op(OP_SLL, 32'hcafe_f00d, 32'd0, '0, 1'b0));
    send_op(make_op(OP_SLL, 32'h0000_0003, 32'd31, '0, 1'b0));
    send_op(make_op(OP_SLL, 32'h0000_00ff, 32'd33, '0, 1'b0));
    send_op(make_op(OP_SRL, 32'h8000_0000, 32'd4, '0, 1'b0));
    send_op(make_op(OP_SRL, 32'h8765_4321, 32'd0, '0, 1'b0));
    send_op(make_op(OP_SRL, 32'hffff_ffff, 32'd63, '0, 1'b0));
    send_op(make_op(OP_SRA, 32'h8000_0000, 32'd31, '0, 1'b0));
    send_op(make_op(OP_SRA, 32'h9000_0000, 32'd0, '0, 1'b0));
    send_op(make_op(OP_SRA, 32'hf000_0000, 32'd36, '0, 1'b0));
    send_op(make_op(OP_SLL, 32'h0000_0101, '0, 32'd7, 1'b1));
    send_op(make_op(OP_SRL, 32'hf000_0000, '0, 32'd12, 1'b1));
    send_op(make_op(OP_SRA, 32'h8000_0002, '0, 32'd1, 1'b1));
  endtask

  task automatic compare_ops();
    send_op(make_op(OP_SLT, 32'h8000_0000, 32'd1, '0, 1'b0));
    send_op(make_op(OP_SLT, 32'd1, 32'h8000_0000, '0, 1'b0));
    send_op(make_op(OP_SLT, 32'hffff_ffff, 32'd0, '0, 1'b0));
    send_op(make_op(OP_SLT, 32'd42, 32'd42, '0, 1'b0));
    send_op(make_op(OP_SLTU, 32'hffff_ffff, 32'd0, '0, 1'b0));
    send_op(make_op(OP_SLTU, 32'd0, 32'hffff_ffff, '0, 1'b0));
    send_op(make_op(OP_SLTU, 32'd0, 32'd1, '0, 1'b0));
    send_op(make_op(OP_SLTU, 32'd7, 32'd0, '0, 1'b0));
    send_op(make_op(OP_SLT, 32'hffff_fffe, '0, 32'hffff_ffff, 1'b1));
    send_op(make_op(OP_SLTU, 32'd5, '0, 32'hffff_ffff, 1'b1));
  endtask

  // scoreboard, the queue follows every transfer at the rising edge
  always @(posedge clk_core) begin
    if (rst_core) begin
      if (flush_req) begin
        // a flush drops everything in flight
        expected_q.delete();
      end else begin
        if (in_valid && in_ready) begin
          expected_q.push_back({ref_result(in_data), in_data.pc});
        end
        if (out_valid && out_ready) begin
          if (expected_q.size() == 0) begin
            stop_run("a result appeared with no operation pending");
          end else begin
            expected_entry = expected_q.pop_front();
            check_value(out_pc, expected_entry[31:0], "pc of result");
            check_value(out_result, expected_entry[63:32], "result");
            checked_count = checked_count + 1;
          end
        end
      end
      // a stalled input needs outputs that were held back recently
      if (!in_ready && ready_run >= FREE_RUN) begin
        stop_run("in_ready is low although outputs were not blocked");
      end
      ready_run = out_ready ? ready_run + 1 : 0;
    end
  end

  always @(posedge clk_core) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > CYCLE_LIMIT) begin
      stop_run($sformatf("the run timed out after %0d cycles", CYCLE_LIMIT));
    end
  end

  initial begin
    int          kind;
    int          n;
    word         a;
    word         b;
    word         imm;
    logic [31:0] r;
    logic        use_imm;
    in_valid      = 1'b0;
    in_data       = '0;
    out_ready     = 1'b1;
    flush_req     = 1'b0;
    ready_mode    = 0;
    ready_run     = 0;
    cycle_count   = 0;
    checked_count = 0;
    rng_state     = 32'd45;
    pc_counter    = 32'h0000_1000;

    wait (rst_core === 1'b1);
    @(posedge clk_core);
    check_value(in_ready, 1'b1, "in_ready after reset");
    check_value(out_valid, 1'b0, "out_valid after reset");
    check_value(flush_ack, 1'b0, "flush_ack after reset");

    arith_ops();
    shift_ops();
    compare_ops();
    wait_drained();

    // one operation per lane on an empty cluster
    for (int k = 0; k < 2; k++) begin
      wait_drained();
      idle_cycle();
      send_op(make_op(OP_ADD + 5 * k, 32'd9, 32'd2, '0, 1'b0));
      n = 0;
      do begin
        idle_cycle();
        n = n + 1;
      end while (!out_valid);
      check_value(n, 3, "cycles from input transfer to out_valid");
    end
    wait_drained();

    // bursts of random stalls alternate with free running output
    for (int i = 0; i < NUM_RANDOM; i++) begin
      ready_mode = ((i / 250) % 2 == 0) ? 1 : 0;
      kind = next_random() % NUM_KINDS;
      a    = next_random();
      b    = ((next_random() % 4) == 0) ? a : next_random();
      r    = next_random();
      if (kind == OP_LUI || kind == OP_AUIPC) begin
        imm = r & 32'hffff_f000;
      end else begin
        imm = {{20{r[11]}}, r[11:0]};
      end
      use_imm = (next_random() & 32'd1) != 0;
      send_op(make_op(kind, a, b, imm, use_imm));
      if ((next_random() % 5) == 0) begin
        idle_cycle();
      end
    end
    ready_mode = 0;
    wait_drained();

    // operations held in the lanes when the flush arrives
    // an odd count leaves the dispatch pointer on lane 1
    ready_mode = 2;
    send_op(make_op(OP_ADD, 32'd1, 32'd2, '0, 1'b0));
    send_op(make_op(OP_SUB, 32'd10, 32'd4, '0, 1'b0));
    send_op(make_op(OP_XOR, 32'hffff_0000, 32'h00ff_ff00, '0, 1'b0));
    flush_cluster();
    repeat (6) idle_cycle();

    // both pointers restart at lane 0
    arith_ops();
    wait_drained();

    // thirteen results leave both pointers on lane 1
    // an idle flush has to rewind the merger as well
    flush_cluster();
    arith_ops();
    wait_drained();
    repeat (4) idle_cycle();

    if (expected_q.size() == 0) begin
      $display("%0d results checked", checked_count);
      $display("all tests passed");
      $finish;
    end else begin
      stop_run($sformatf("%0d results never appeared", expected_q.size()));
    end
  end

endmodule

`default_nettype wire

//--- alu_cluster.f
verilog/alu_pkg.sv
verilog/alu_dispatch.sv
verilog/alu_setup_stage.sv
verilog/alu_shift_add_stage.sv
verilog/alu_skid_buffer.sv
verilog/alu_lane.sv
verilog/alu_commit_merge.sv
verilog/alu_cluster.sv
bench/alu_tb_clock.sv
bench/alu_cluster_tb.sv

//--- Bender.yml
package:
  name: alu_cluster

sources:
  - files:
      - verilog/alu_pkg.sv
      - verilog/alu_dispatch.sv
      - verilog/alu_setup_stage.sv
      - verilog/alu_shift_add_stage.sv
      - verilog/alu_skid_buffer.sv
      - verilog/alu_lane.sv
      - verilog/alu_commit_merge.sv
      - verilog/alu_cluster.sv
  - target: test
    files:
      - bench/alu_tb_clock.sv
      - bench/alu_cluster_tb.sv
